// ==== mmu_cache.f ====
+incdir+source
source/cache_addr_pkg.sv
source/cache_data_pkg.sv
source/sync_ram.sv
source/tlb.sv
source/cache_store.sv
source/miss_ctrl.sv
source/mmu_cache.sv
tests/mem_model.sv
tests/mmu_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; exit status follows the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mmu_cache_tb -f mmu_cache.f -o mmu_cache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/mmu_cache_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// ==== tests/mmu_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_cache_tb;

  localparam logic [31:0] FILL_KEY  = 32'h3c96e1a5;
  localparam logic [31:0] SEED      = 32'hc2824f1b;
  localparam int          REQ_COUNT = 100;
  localparam int          MISS_NS   = 20 * 20;   // worst case miss, in ns.

  typedef struct packed {
    logic        quick;
    logic        load;
    logic        fault;
    logic [31:0] rdata;
    logic [31:0] acc_cyc;
  } resp_t;

  typedef struct packed {
    logic        we;
    logic [29:0] addr;
    logic [31:0] data;
  } xfer_t;

  logic        CPU_CLK = 1'b0;
  logic        RST = 1'b0;
  logic        cpu_req = 1'b0, cpu_we = 1'b0, cpu_tlb_we = 1'b0;
  logic [31:0] cpu_addr = '0, cpu_wdata = '0;
  logic        cpu_ready, cpu_ack, cpu_fault, mem_req, mem_we, mem_ack;
  logic [31:0] cpu_rdata, mem_wdata, mem_rdata;
  logic [29:0] mem_addr;

  resp_t       issued[$], pend[$];
  xfer_t       xfers[$];
  logic [31:0] ref_mem [logic [29:0]];
  logic        ref_tv [256], ref_lv [128];
  logic [13:0] ref_vtag [256], ref_frame [256];
  logic [28:0] ref_ltag [128];
  logic [31:0] rng = SEED;
  logic [31:0] cyc = '0;
  int          value_errs = 0, proto_errs = 0;

  mmu_cache dut_i (.*);

  mem_model #(.FILL_KEY(FILL_KEY), .SEED(SEED)) mem_i (.*);

  always #10 CPU_CLK = ~CPU_CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] mem_word(input logic [29:0] pa);
    return ref_mem.exists(pa) ? ref_mem[pa] : ({2'b00, pa} ^ FILL_KEY);
  endfunction

  task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp === got)
    else
    begin
      value_errs++;
      $display("error %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok)
    else
    begin
      proto_errs++;
      $display("%s", what);
    end
  endtask

  task automatic push_xfer(input logic we, input logic [29:0] pa, input logic [31:0] d);
    xfer_t x;
    x.we   = we;
    x.addr = pa;
    x.data = d;
    xfers.push_back(x);
  endtask

  // works out the expected answer and memory traffic, then drives the request.
  task automatic request(input logic we, input logic tlbw, input logic [31:0] va,
                         input logic [31:0] wd);
    resp_t       e;
    logic [7:0]  ti;
    logic [6:0]  ln;
    logic [29:0] pa;
    logic        hitr;
    ti = va[17:10];
    ln = va[9:3];
    pa = {ref_frame[ti], va[17:2]};   // frame then virtual bits 17 to 2.
    hitr = ref_lv[ln] && (ref_ltag[ln] == pa[29:1]);
    e.load    = !we && !tlbw;
    e.fault   = !tlbw && (!ref_tv[ti] || (ref_vtag[ti] != va[31:18]));
    e.quick   = tlbw || e.fault || (e.load && hitr);
    e.rdata   = mem_word(pa);
    e.acc_cyc = '0;
    if (tlbw)
    begin
      ref_tv[ti]    = wd[28];
      ref_vtag[ti]  = wd[27:14];
      ref_frame[ti] = wd[13:0];
    end
    else if (!e.fault && we)
    begin
      push_xfer(1'b1, pa, wd);
      ref_mem[pa] = wd;   // no allocate on a store.
    end
    else if (!e.fault && !hitr)
    begin
      push_xfer(1'b0, pa, '0);
      push_xfer(1'b0, pa ^ 30'd1, '0);
      ref_lv[ln]   = 1'b1;
      ref_ltag[ln] = pa[29:1];
    end
    issued.push_back(e);
    cpu_req    = 1'b1;
    cpu_we     = we;
    cpu_tlb_we = tlbw;
    cpu_addr   = va;
    cpu_wdata  = wd;
    while (!cpu_ready)
    begin
      @(posedge CPU_CLK);
      #2;
    end
    @(posedge CPU_CLK);
    #2;
  endtask

  task automatic map_page(input logic [13:0] vtag, input logic [7:0] ti, input logic [13:0] fr);
    request(1'b0, 1'b1, {vtag, ti, 10'h0}, {3'b000, 1'b1, vtag, fr});
  endtask

  task automatic idle();
    cpu_req = 1'b0;
    @(posedge CPU_CLK);
    #2;
  endtask

  // outputs are stable at the falling edge.
  always @(negedge CPU_CLK)
  begin
    resp_t e;
    xfer_t x;
    if (cpu_ack)
    begin
      check_true(pend.size() != 0, "cpu_ack arrived with no request outstanding");
      if (pend.size() != 0)
      begin
        e = pend.pop_front();
        check_hex("cpu_fault", {31'h0, e.fault}, {31'h0, cpu_fault});
        if (e.load && !e.fault)
          check_hex("cpu_rdata", e.rdata, cpu_rdata);
        if (e.quick)
        begin
          check_true(cyc == e.acc_cyc + 1, "one cycle answer came late");
          check_true(!mem_req, "memory request during a one cycle answer");
        end
      end
    end
    if (cpu_req && cpu_ready && issued.size() != 0)
    begin
      e = issued.pop_front();
      e.acc_cyc = cyc;
      pend.push_back(e);
    end
    if (mem_req && mem_ack)
    begin
      check_true(xfers.size() != 0, "memory transfer that no request should cause");
      if (xfers.size() != 0)
      begin
        x = xfers.pop_front();
        check_hex("mem_we", {31'h0, x.we}, {31'h0, mem_we});
        check_hex("mem_addr", {2'b00, x.addr}, {2'b00, mem_addr});
        if (x.we)
          check_hex("mem_wdata", x.data, mem_wdata);
      end
    end
    cyc <= cyc + 1;
  end

  initial
  begin
    #(REQ_COUNT * MISS_NS + 2000);
    $display("watchdog expired before the requests completed");
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    logic [31:0] va_a, va;
    foreach (ref_tv[i]) ref_tv[i] = 1'b0;
    foreach (ref_lv[i]) ref_lv[i] = 1'b0;
    repeat (8) @(posedge CPU_CLK);
    #2;
    RST = 1'b1;
    check_true(cpu_ready && !cpu_ack && !mem_req && !cpu_fault, "outputs wrong after reset");
    va_a = {14'h0123, 8'h05, 10'h000};
    map_page(14'h0123, 8'h05, 14'h02a1);
    request(1'b0, 1'b0, va_a + 32'h14, '0);        // miss, refill of the line.
    request(1'b0, 1'b0, va_a + 32'h10, '0);        // hit on the other word.
    request(1'b0, 1'b0, va_a + 32'h14, '0);        // back to back hits.
    idle();
    request(1'b0, 1'b0, {14'h0001, 8'h07, 10'h010}, '0);      // unmapped page.
    request(1'b1, 1'b0, {14'h0999, 8'h05, 10'h014}, 32'h1);   // wrong virtual tag.
    request(1'b1, 1'b0, va_a + 32'h14, 32'hdeadbeef);
    request(1'b0, 1'b0, va_a + 32'h14, '0);
    request(1'b1, 1'b0, va_a + 32'h40, 32'h12345678);         // line not cached.
    request(1'b0, 1'b0, va_a + 32'h40, '0);
    map_page(14'h0123, 8'h05, 14'h0777);                      // remap to a new frame.
    request(1'b0, 1'b0, va_a + 32'h14, '0);
    for (int p = 0; p < 4; p++)
    begin
      rng = xorshift(rng);
      map_page(14'h0042, 8'h10 + p[7:0], rng[13:0]);
    end
    for (int n = 0; n < 60; n++)
    begin
      rng = xorshift(rng);
      va  = {14'h0042, 6'h04, rng[1:0], 3'b000, rng[6:2], 2'b00};
      request(rng[8], 1'b0, va, xorshift(rng));
      if (!rng[9])
        idle();
    end
    idle();
    while (pend.size() != 0 || issued.size() != 0)
      @(posedge CPU_CLK);
    repeat (4) @(posedge CPU_CLK);
    check_true(xfers.size() == 0, "expected memory transfers never happened");
    $display("closing: %0d value errors, %0d protocol errors", value_errs, proto_errs);
    if (value_errs + proto_errs == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
  parameter logic [31:0] FILL_KEY = 32'h3c96e1a5,
  parameter logic [31:0] SEED     = 32'hc2824f1b
) (
  input  wire         CPU_CLK,
  input  wire         RST,
  input  wire         mem_req,
  input  wire         mem_we,
  input  wire  [29:0] mem_addr,
  input  wire  [31:0] mem_wdata,
  output logic        mem_ack = 1'b0,
  output logic [31:0] mem_rdata = '0
);

  logic [31:0] words [logic [29:0]];   // sparse storage.
  logic [31:0] rng = SEED;
  logic [1:0]  wait_cnt = '0;
  logic [1:0]  delay = '0;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  always @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      wait_cnt = '0;
      delay    = '0;
    end
    else if (mem_req)
    begin
      if (mem_ack)
      begin
        if (mem_we)
          words[mem_addr] = mem_wdata;
        wait_cnt = '0;
        rng      = next_rand(rng);
        delay    = rng[1:0];   // 0 to 3 cycles for the next transfer.
      end
      else
        wait_cnt = wait_cnt + 2'd1;
    end
    #2;
    mem_ack   = mem_req && (wait_cnt == delay);
    mem_rdata = words.exists(mem_addr) ? words[mem_addr] : ({2'b00, mem_addr} ^ FILL_KEY);
  end

endmodule

`default_nettype wire

// ==== source/mmu_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_cache_settings.svh"

module mmu_cache (
  input  wire         CPU_CLK,
  input  wire         RST,
  input  wire         cpu_req,
  input  wire         cpu_we,
  input  wire         cpu_tlb_we,
  input  wire  [31:0] cpu_addr,
  input  wire  [31:0] cpu_wdata,
  output logic        cpu_ready,
  output logic        cpu_ack,
  output logic [31:0] cpu_rdata,
  output logic        cpu_fault,
  output logic        mem_req,
  output logic        mem_we,
  output logic [29:0] mem_addr,
  output logic [31:0] mem_wdata,
  input  wire         mem_ack,
  input  wire  [31:0] mem_rdata
);

  cache_addr_pkg::vaddr_u        lookup_addr, entry_addr;
  cache_data_pkg::wdata_u        entry_data, store_data;
  logic                          entry_we, fault, hit;
  logic [`MMU_CACHE_FRAME_W-1:0] frame;
  logic [31:0]                   cache_rdata, fill_word;
  logic                          fill_we, fill_tag_we, store_we;
  logic [`MMU_CACHE_IDX_W-1:0]   fill_idx;

  miss_ctrl ctrl_i (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .cpu_req     (cpu_req),
    .cpu_we      (cpu_we),
    .cpu_tlb_we  (cpu_tlb_we),
    .cpu_addr    (cpu_addr),
    .cpu_wdata   (cpu_wdata),
    .cpu_ready   (cpu_ready),
    .cpu_ack     (cpu_ack),
    .cpu_rdata   (cpu_rdata),
    .cpu_fault   (cpu_fault),
    .frame       (frame),
    .fault       (fault),
    .hit         (hit),
    .cache_rdata (cache_rdata),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .lookup_addr (lookup_addr),
    .fill_we     (fill_we),
    .fill_idx    (fill_idx),
    .fill_word   (fill_word),
    .fill_tag_we (fill_tag_we),
    .store_we    (store_we),
    .store_data  (store_data),
    .entry_we    (entry_we),
    .entry_addr  (entry_addr),
    .entry_data  (entry_data)
  );

  tlb tlb_i (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .lookup_addr (lookup_addr),
    .entry_we    (entry_we),
    .entry_addr  (entry_addr),
    .entry_data  (entry_data),
    .frame       (frame),
    .fault       (fault)
  );

  cache_store store_i (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .lookup_addr (lookup_addr),
    .frame       (frame),
    .fill_we     (fill_we),
    .fill_idx    (fill_idx),
    .fill_word   (fill_word),
    .fill_tag_we (fill_tag_we),
    .store_we    (store_we),
    .store_data  (store_data),
    .hit         (hit),
    .rdata       (cache_rdata)
  );

endmodule

`default_nettype wire

// ==== source/miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_cache_settings.svh"

module miss_ctrl (
  input  wire                           CPU_CLK,
  input  wire                           RST,
  input  wire                           cpu_req,
  input  wire                           cpu_we,
  input  wire                           cpu_tlb_we,
  input  wire cache_addr_pkg::vaddr_u   cpu_addr,
  input  wire cache_data_pkg::wdata_u   cpu_wdata,
  output logic                          cpu_ready,
  output logic                          cpu_ack,
  output logic [31:0]                   cpu_rdata,
  output logic                          cpu_fault,
  input  wire [`MMU_CACHE_FRAME_W-1:0]  frame,
  input  wire                           fault,
  input  wire                           hit,
  input  wire [31:0]                    cache_rdata,
  output logic                          mem_req,
  output logic                          mem_we,
  output logic [29:0]                   mem_addr,
  output logic [31:0]                   mem_wdata,
  input  wire                           mem_ack,
  input  wire [31:0]                    mem_rdata,
  output cache_addr_pkg::vaddr_u        lookup_addr,
  output logic                          fill_we,
  output logic [`MMU_CACHE_IDX_W-1:0]   fill_idx,
  output logic [31:0]                   fill_word,
  output logic                          fill_tag_we,
  output logic                          store_we,
  output cache_data_pkg::wdata_u        store_data,
  output logic                          entry_we,
  output cache_addr_pkg::vaddr_u        entry_addr,
  output cache_data_pkg::wdata_u        entry_data
);

  localparam logic [2:0] ST_LOOKUP = 3'd0;
  localparam logic [2:0] ST_FILL1  = 3'd1;
  localparam logic [2:0] ST_FILL2  = 3'd2;
  localparam logic [2:0] ST_WRITE  = 3'd3;
  localparam logic [2:0] ST_RESP   = 3'd4;

  logic [2:0]             state;
  logic                   req_v_q, req_we_q, req_tlb_q;
  cache_addr_pkg::vaddr_u req_addr_q;
  cache_data_pkg::wdata_u req_wdata_q;
  logic [31:0]            resp_word_q;
  logic                   mem_req_q, word_sel_q;
  logic                   in_lookup, quick, go_busy, accept, mem_done;

  assign in_lookup = (state == ST_LOOKUP);
  assign quick     = req_v_q && (req_tlb_q || fault || (!req_we_q && hit));   // one cycle answer.
  assign go_busy   = in_lookup && req_v_q && !quick;
  assign cpu_ready = in_lookup && !go_busy;
  assign accept    = cpu_req && cpu_ready;
  assign mem_done  = mem_req_q && mem_ack;

  assign cpu_ack   = (in_lookup && quick) || (state == ST_RESP);
  assign cpu_fault = in_lookup && req_v_q && !req_tlb_q && fault;
  assign cpu_rdata = (state == ST_RESP) ? resp_word_q : cache_rdata;

  // hold the lookup on the request while busy, keeps frame and tag stable.
  assign lookup_addr = cpu_ready ? cpu_addr : req_addr_q;

  assign entry_we   = accept && cpu_tlb_we;
  assign entry_addr = cpu_addr;
  assign entry_data = cpu_wdata;

  assign store_we    = in_lookup && req_v_q && req_we_q && !req_tlb_q && !fault;
  assign store_data  = req_wdata_q;
  assign fill_we     = ((state == ST_FILL1) || (state == ST_FILL2)) && mem_done;
  assign fill_tag_we = (state == ST_FILL2) && mem_done;
  assign fill_idx    = {req_addr_q.cache.idx[`MMU_CACHE_IDX_W-1:1], word_sel_q};
  assign fill_word   = mem_rdata;

  assign mem_req   = mem_req_q;
  assign mem_we    = (state == ST_WRITE);
  assign mem_addr  = {frame, req_addr_q.tlb.tidx, fill_idx};   // physical word address.
  assign mem_wdata = req_wdata_q.word;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= ST_LOOKUP;
      req_v_q    <= 1'b0;
      mem_req_q  <= 1'b0;
      word_sel_q <= 1'b0;
    end
    else
    begin
      case (state)
        ST_LOOKUP:
        begin
          req_v_q <= accept;
          if (go_busy)
          begin
            state      <= req_we_q ? ST_WRITE : ST_FILL1;
            mem_req_q  <= 1'b1;
            word_sel_q <= req_addr_q.cache.idx[0];   // requested word goes first.
          end
        end
        ST_FILL1:
        begin
          if (mem_done)
          begin
            mem_req_q  <= 1'b0;
            word_sel_q <= ~word_sel_q;
            state      <= ST_FILL2;
          end
        end
        ST_FILL2:
        begin
          if (!mem_req_q)
            mem_req_q <= 1'b1;   // after one idle cycle.
          else if (mem_ack)
          begin
            mem_req_q <= 1'b0;
            state     <= ST_RESP;
          end
        end
        ST_WRITE:
        begin
          if (mem_done)
          begin
            mem_req_q <= 1'b0;
            state     <= ST_RESP;
          end
        end
        default:
          state <= ST_LOOKUP;
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      req_we_q    <= cpu_we;
      req_tlb_q   <= cpu_tlb_we;
      req_addr_q  <= cpu_addr;
      req_wdata_q <= cpu_wdata;
    end
    if ((state == ST_FILL1) && mem_done)
      resp_word_q <= mem_rdata;
  end

endmodule

`default_nettype wire

// ==== source/cache_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_cache_settings.svh"

module cache_store (
  input  wire                           CPU_CLK,
  input  wire                           RST,
  input  wire cache_addr_pkg::vaddr_u   lookup_addr,
  input  wire [`MMU_CACHE_FRAME_W-1:0]  frame,
  input  wire                           fill_we,
  input  wire [`MMU_CACHE_IDX_W-1:0]    fill_idx,
  input  wire [31:0]                    fill_word,
  input  wire                           fill_tag_we,
  input  wire                           store_we,
  input  wire cache_data_pkg::wdata_u   store_data,
  output logic                          hit,
  output logic [31:0]                   rdata
);

  localparam int WORDS = 1 << `MMU_CACHE_IDX_W;
  localparam int LINES = WORDS / 2;

  logic [LINES-1:0]                    line_valid;
  logic                                line_valid_q;
  cache_addr_pkg::vaddr_u              lookup_q;
  logic [cache_addr_pkg::LINE_W-1:0]   rd_line;
  logic [cache_addr_pkg::LINE_W-1:0]   wr_line;
  logic [`MMU_CACHE_PTAG_W-1:0]        tag_rdata;
  logic [`MMU_CACHE_PTAG_W-1:0]        cur_tag;
  logic                                data_we;
  logic [`MMU_CACHE_IDX_W-1:0]         data_waddr;
  logic [31:0]                         data_wdata;

  assign rd_line = lookup_addr.cache.idx[`MMU_CACHE_IDX_W-1:1];
  assign wr_line = fill_idx[`MMU_CACHE_IDX_W-1:1];
  assign cur_tag = {frame, lookup_q.tlb.tidx};   // physical tag of the looked up address.

  // refill has the port, a store only updates a line it hits.
  assign data_we    = fill_we || (store_we && hit);
  assign data_waddr = fill_we ? fill_idx : lookup_q.cache.idx;
  assign data_wdata = fill_we ? fill_word : store_data.word;

  sync_ram #(
    .WIDTH (32),
    .DEPTH (WORDS)
  ) data_ram_i (
    .CPU_CLK (CPU_CLK),
    .raddr   (lookup_addr.cache.idx),
    .rdata   (rdata),
    .we      (data_we),
    .waddr   (data_waddr),
    .wdata   (data_wdata)
  );

  sync_ram #(
    .WIDTH (`MMU_CACHE_PTAG_W),
    .DEPTH (LINES)
  ) tag_ram_i (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_line),
    .rdata   (tag_rdata),
    .we      (fill_tag_we),
    .waddr   (wr_line),
    .wdata   (cur_tag)
  );

  assign hit = line_valid_q && (tag_rdata == cur_tag);

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      line_valid   <= '0;
      line_valid_q <= 1'b0;
    end
    else
    begin
      line_valid_q <= line_valid[rd_line];
      if (fill_tag_we)
        line_valid[wr_line] <= 1'b1;   // tag lands with the second word.
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    lookup_q <= lookup_addr;
  end

endmodule

`default_nettype wire

// ==== source/tlb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_cache_settings.svh"

module tlb (
  input  wire                           CPU_CLK,
  input  wire                           RST,
  input  wire cache_addr_pkg::vaddr_u   lookup_addr,
  input  wire                           entry_we,
  input  wire cache_addr_pkg::vaddr_u   entry_addr,
  input  wire cache_data_pkg::wdata_u   entry_data,
  output logic [`MMU_CACHE_FRAME_W-1:0] frame,
  output logic                          fault
);

  localparam int ENTRIES = 1 << `MMU_CACHE_TLB_IDX_W;
  localparam int ENTRY_W = `MMU_CACHE_VTAG_W + `MMU_CACHE_FRAME_W;

  logic [ENTRIES-1:0]           entry_valid;
  logic                         entry_valid_q;
  logic [`MMU_CACHE_VTAG_W-1:0] lookup_vtag_q;
  logic [`MMU_CACHE_VTAG_W-1:0] entry_vtag;
  logic [ENTRY_W-1:0]           ram_rdata;

  // vtag and frame per translation index.
  sync_ram #(
    .WIDTH (ENTRY_W),
    .DEPTH (ENTRIES)
  ) entry_ram_i (
    .CPU_CLK (CPU_CLK),
    .raddr   (lookup_addr.tlb.tidx),
    .rdata   (ram_rdata),
    .we      (entry_we),
    .waddr   (entry_addr.tlb.tidx),
    .wdata   ({entry_data.entry.vtag, entry_data.entry.frame})
  );

  assign {entry_vtag, frame} = ram_rdata;

  // page not mapped, or mapped for another virtual tag.
  assign fault = !entry_valid_q || (entry_vtag != lookup_vtag_q);

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      entry_valid   <= '0;
      entry_valid_q <= 1'b0;
    end
    else
    begin
      entry_valid_q <= entry_valid[lookup_addr.tlb.tidx];   // same timing as the RAM.
      if (entry_we)
        entry_valid[entry_addr.tlb.tidx] <= entry_data.entry.valid;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    lookup_vtag_q <= lookup_addr.tlb.vtag;
  end

endmodule

`default_nettype wire

// ==== source/sync_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 256
) (
  input  wire                     CPU_CLK,
  input  wire [$clog2(DEPTH)-1:0] raddr,
  output logic [WIDTH-1:0]        rdata,
  input  wire                     we,
  input  wire [$clog2(DEPTH)-1:0] waddr,
  input  wire [WIDTH-1:0]         wdata
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge CPU_CLK)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

  // read returns the old word on a same address write.
  always_ff @(posedge CPU_CLK)
  begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== source/cache_data_pkg.sv ====
`default_nettype none

`include "mmu_cache_settings.svh"

package cache_data_pkg;

  localparam int ENTRY_PAD_W = 32 - 1 - `MMU_CACHE_VTAG_W - `MMU_CACHE_FRAME_W;

  // translation entry as written by the CPU.
  typedef struct packed {
    logic [ENTRY_PAD_W-1:0]        pad;    // unused.
    logic                          valid;
    logic [`MMU_CACHE_VTAG_W-1:0]  vtag;
    logic [`MMU_CACHE_FRAME_W-1:0] frame;
  } tlb_entry_t;

  typedef union packed {
    logic [31:0] word;
    tlb_entry_t  entry;
  } wdata_u;

endpackage

`default_nettype wire

// ==== source/cache_addr_pkg.sv ====
`default_nettype none

`include "mmu_cache_settings.svh"

package cache_addr_pkg;

  localparam int OFF_W      = 2;                                 // byte offset in a word.
  localparam int LINE_W     = `MMU_CACHE_IDX_W - 1;              // line index bits.
  localparam int UPPER_W    = 32 - `MMU_CACHE_IDX_W - OFF_W;
  localparam int PAGE_OFF_W = 32 - `MMU_CACHE_VTAG_W - `MMU_CACHE_TLB_IDX_W;

  // cache view, bit 2 picks the word within a line.
  typedef struct packed {
    logic [UPPER_W-1:0]          upper;
    logic [`MMU_CACHE_IDX_W-1:0] idx;
    logic [OFF_W-1:0]            off;
  } cache_view_t;

  // translation view.
  typedef struct packed {
    logic [`MMU_CACHE_VTAG_W-1:0]    vtag;
    logic [`MMU_CACHE_TLB_IDX_W-1:0] tidx;
    logic [PAGE_OFF_W-1:0]           page_off;
  } tlb_view_t;

  typedef union packed {
    cache_view_t cache;
    tlb_view_t   tlb;
  } vaddr_u;

endpackage

`default_nettype wire

// ==== source/mmu_cache_settings.svh ====
`ifndef MMU_CACHE_SETTINGS_SVH
`define MMU_CACHE_SETTINGS_SVH

// cache word index, 256 words in lines of two.
`define MMU_CACHE_IDX_W 8

// translation index, virtual address bits 17 to 10.
`define MMU_CACHE_TLB_IDX_W 8

// physical frame number.
`define MMU_CACHE_FRAME_W 14

// virtual page tag, virtual address bits 31 to 18.
`define MMU_CACHE_VTAG_W 14

// stored cache tag is the frame followed by the translation index.
`define MMU_CACHE_PTAG_W 22

`endif
